// ==== hdl/fetch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the instruction fetch subsystem
// Machine word, fetch-execute register layout, BTB counter states
// and the reset PC, BTB geometry and bus byte order constants
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

    // One machine word, used for PCs, addresses and instructions
    typedef logic [31:0] word_t;

    // Fetch to execute pipeline register
    typedef struct packed {
        // High when the slot holds a real instruction
        logic  token;
        word_t pc;
        // Return address for jumps in execute
        word_t pc4;
        word_t instr;
        // BTB said taken when this word was fetched
        logic  prediction;
    } fetch_ex_t;

    // Two-bit saturating counter per BTB entry
    // Upper two states predict taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } btb_state_e;

    // First fetch address out of reset
    localparam word_t RESET_PC = 32'h8000_0000;

    // Direct-mapped BTB, index from pc[5:2], tag from pc[31:6]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_W = 4;
    localparam int BTB_TAG_W   = 26;

    // Bus returns words little end first
    // Fetch stage swaps bytes when this is set
    localparam logic BUS_LITTLE_ENDIAN = 1'b1;

endpackage

// ==== hdl/fetch_hazard_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Hazard unit to fetch stage interface
// Carries PC enable, pipeline stall and flush, read strobe and the
// next-PC select with the trap and redirect targets
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface fetch_hazard_if;
    import fetch_pkg::*;

    // Controls from the hazard unit
    logic  pc_en;
    logic  if_ex_stall;
    logic  if_ex_flush;
    logic  iren;
    // Redirect from execute selects brj_addr
    logic  npc_sel;
    // Trap PC beats everything else
    logic  insert_priv_pc;
    word_t priv_pc;
    word_t brj_addr;

    // Bus status seen by the fetch stage
    logic  i_mem_busy;

    modport hazard (
        output pc_en, if_ex_stall, if_ex_flush, iren,
        output npc_sel, insert_priv_pc, priv_pc, brj_addr,
        input  i_mem_busy
    );

    modport fetch (
        input  pc_en, if_ex_stall, if_ex_flush, iren,
        input  npc_sel, insert_priv_pc, priv_pc, brj_addr,
        output i_mem_busy
    );

endinterface

// ==== hdl/predictor_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch predictor interface
// Lookup port for the fetch stage, training port from execute
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface predictor_if;
    import fetch_pkg::*;

    // Lookup
    word_t current_pc;
    logic  predict_taken;
    word_t target_addr;

    // Training, resolved branches from execute
    logic  update_en;
    word_t update_pc;
    word_t update_target;
    logic  update_taken;

    // Fetch side only sees the lookup
    modport access (
        output current_pc,
        input  predict_taken, target_addr
    );

    modport predictor (
        input  current_pc,
        input  update_en, update_pc, update_target, update_taken,
        output predict_taken, target_addr
    );

endinterface

// ==== hdl/branch_target_buffer.sv ====
////////////////////////////////////////////////////////////////////////////
// Direct-mapped branch target buffer
// Per entry a valid bit, tag, target and two-bit counter
// Combinational lookup, training written on the clock edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_target_buffer (
    input logic CLK,
    input logic nRST,
    predictor_if.predictor pred
);
    import fetch_pkg::*;

    logic [BTB_TAG_W-1:0] tags    [BTB_ENTRIES];
    word_t                targets [BTB_ENTRIES];
    btb_state_e           states  [BTB_ENTRIES];
    logic                 valid   [BTB_ENTRIES];

    logic [BTB_INDEX_W-1:0] rd_idx, wr_idx;
    logic [BTB_TAG_W-1:0]   rd_tag, wr_tag;
    logic                   wr_hit;
    btb_state_e             next_state;

    // Index sits just above the word offset, tag is the rest
    assign rd_idx = pred.current_pc[2 +: BTB_INDEX_W];
    assign rd_tag = pred.current_pc[31 -: BTB_TAG_W];
    assign wr_idx = pred.update_pc[2 +: BTB_INDEX_W];
    assign wr_tag = pred.update_pc[31 -: BTB_TAG_W];

    // Taken only on a live tag match in an upper state
    assign pred.predict_taken = valid[rd_idx] && (tags[rd_idx] == rd_tag)
                                && (states[rd_idx] inside {weak_taken, strong_taken});
    assign pred.target_addr   = targets[rd_idx];

    assign wr_hit = valid[wr_idx] && (tags[wr_idx] == wr_tag);

    // Counter step toward the outcome, saturating
    always_comb begin
        if (!wr_hit) begin
            // Fresh entry starts weak on the side of the outcome
            next_state = pred.update_taken ? weak_taken : weak_not_taken;
        end else begin
            case (states[wr_idx])
                strong_not_taken: next_state = pred.update_taken ? weak_not_taken
                                                                 : strong_not_taken;
                weak_not_taken:   next_state = pred.update_taken ? weak_taken
                                                                 : strong_not_taken;
                weak_taken:       next_state = pred.update_taken ? strong_taken
                                                                 : weak_not_taken;
                default:          next_state = pred.update_taken ? strong_taken
                                                                 : weak_taken;
            endcase
        end
    end

    // Valid bits and counters
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid[i]  <= 1'b0;
                states[i] <= weak_not_taken;
            end
        end else if (pred.update_en) begin
            valid[wr_idx]  <= 1'b1;
            states[wr_idx] <= next_state;
        end
    end

    // Tag and target storage
    always_ff @(posedge CLK) begin
        if (pred.update_en) begin
            tags[wr_idx] <= wr_tag;
            // Keep the old target when a known branch falls through
            if (!wr_hit || pred.update_taken) begin
                targets[wr_idx] <= pred.update_target;
            end
        end
    end

endmodule

// ==== hdl/fetch_hazard_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Fetch hazard unit
// Turns bus busy, execute stall, redirect and trap requests into
// PC enable, stall, flush, read enable and next-PC select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_hazard_unit (
    input logic CLK,
    input logic nRST,
    input logic imem_busy,
    input logic ex_stall,
    input logic ex_redirect,
    input fetch_pkg::word_t ex_brj_addr,
    input logic priv_insert,
    input fetch_pkg::word_t priv_pc,
    fetch_hazard_if.hazard hz
);
    import fetch_pkg::*;

    logic ready;
    logic change_flow;
    logic read_done;

    // Goes high on the first edge after reset, no read issued before
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ready <= 1'b0;
        end else begin
            ready <= 1'b1;
        end
    end

    assign hz.iren = ready;

    // Trap or redirect throws away whatever is being fetched
    assign change_flow = priv_insert | ex_redirect;

    // Issued read came back this cycle
    assign read_done = ready & ~hz.i_mem_busy;

    // PC moves on a completed fetch, or always on a change of flow
    assign hz.pc_en = change_flow | (read_done & ~ex_stall);

    // Execute holding its slot keeps the register as is
    assign hz.if_ex_stall = ex_stall;

    // Bubble on change of flow, before the first read, or
    // while the bus is still busy and execute wants a new word
    assign hz.if_ex_flush = change_flow | ~ready | (imem_busy & ~ex_stall);

    // Trap wins over redirect
    assign hz.insert_priv_pc = priv_insert;
    assign hz.npc_sel        = ex_redirect & ~priv_insert;

    // Targets passed straight on to the PC mux
    assign hz.priv_pc  = priv_pc;
    assign hz.brj_addr = ex_brj_addr;

endmodule

// ==== hdl/fetch_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Fetch stage of the two-stage pipeline
// PC register and next-PC mux, bus address and read strobe,
// byte swap of the bus word, misaligned fetch report and the
// fetch to execute pipeline register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_stage (
    input logic CLK,
    input logic nRST,
    fetch_hazard_if.fetch hz,
    predictor_if.access pred,
    output fetch_pkg::word_t imem_addr,
    output logic imem_ren,
    input fetch_pkg::word_t imem_rdata,
    input logic imem_busy,
    output fetch_pkg::fetch_ex_t fetch_ex,
    output logic mal_insn,
    output fetch_pkg::word_t badaddr
);
    import fetch_pkg::*;

    word_t pc;
    word_t pc4;
    word_t npc;
    word_t instr;

    // PC register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (hz.pc_en) begin
            pc <= npc;
        end
    end

    // No compressed instructions, step is always one word
    assign pc4 = pc + 32'd4;

    // Trap, then redirect, then BTB, then sequential
    assign npc = hz.insert_priv_pc ? hz.priv_pc
               : hz.npc_sel        ? hz.brj_addr
               : pred.predict_taken ? pred.target_addr
               : pc4;

    assign pred.current_pc = pc;

    // Bus side
    assign imem_addr = pc;
    assign imem_ren  = hz.iren;
    // Busy only matters for a read actually in flight
    assign hz.i_mem_busy = imem_busy & imem_ren;

    // Byte order correction of the returned word
    generate
        if (BUS_LITTLE_ENDIAN) begin : g_swap
            assign instr = {imem_rdata[7:0], imem_rdata[15:8],
                            imem_rdata[23:16], imem_rdata[31:24]};
        end else begin : g_pass
            assign instr = imem_rdata;
        end
    endgenerate

    // Fetch to execute register, flush beats stall
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex <= '0;
        end else if (hz.if_ex_flush) begin
            fetch_ex <= '0;
        end else if (!hz.if_ex_stall) begin
            fetch_ex.token      <= 1'b1;
            fetch_ex.pc         <= pc;
            fetch_ex.pc4        <= pc4;
            fetch_ex.instr      <= instr;
            fetch_ex.prediction <= pred.predict_taken;
        end
    end

    // Word fetch needs the two low address bits clear
    assign mal_insn = (imem_addr[1:0] != 2'b00);
    assign badaddr  = imem_addr;

endmodule

// ==== hdl/fetch_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction fetch subsystem top level
// Hazard unit, BTB and fetch stage behind plain ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_top (
    input  logic             CLK,
    input  logic             nRST,
    // Instruction bus
    output fetch_pkg::word_t imem_addr,
    output logic             imem_ren,
    input  fetch_pkg::word_t imem_rdata,
    input  logic             imem_busy,
    // Execute side
    input  logic             ex_stall,
    input  logic             ex_redirect,
    input  fetch_pkg::word_t ex_brj_addr,
    input  logic             update_en,
    input  fetch_pkg::word_t update_pc,
    input  fetch_pkg::word_t update_target,
    input  logic             update_taken,
    // Trap side
    input  logic             priv_insert,
    input  fetch_pkg::word_t priv_pc,
    // Fetch to execute register
    output logic             fe_token,
    output fetch_pkg::word_t fe_pc,
    output fetch_pkg::word_t fe_pc4,
    output fetch_pkg::word_t fe_instr,
    output logic             fe_prediction,
    // Misaligned fetch report
    output logic             mal_insn,
    output fetch_pkg::word_t badaddr
);
    import fetch_pkg::*;

    fetch_ex_t fetch_ex;

    fetch_hazard_if hz_if ();
    predictor_if    pred_if ();

    // Training comes straight from execute
    assign pred_if.update_en     = update_en;
    assign pred_if.update_pc     = update_pc;
    assign pred_if.update_target = update_target;
    assign pred_if.update_taken  = update_taken;

    fetch_hazard_unit u_hazard (
        .CLK         (CLK),
        .nRST        (nRST),
        .imem_busy   (imem_busy),
        .ex_stall    (ex_stall),
        .ex_redirect (ex_redirect),
        .ex_brj_addr (ex_brj_addr),
        .priv_insert (priv_insert),
        .priv_pc     (priv_pc),
        .hz          (hz_if.hazard)
    );

    branch_target_buffer u_btb (
        .CLK  (CLK),
        .nRST (nRST),
        .pred (pred_if.predictor)
    );

    fetch_stage u_fetch (
        .CLK        (CLK),
        .nRST       (nRST),
        .hz         (hz_if.fetch),
        .pred       (pred_if.access),
        .imem_addr  (imem_addr),
        .imem_ren   (imem_ren),
        .imem_rdata (imem_rdata),
        .imem_busy  (imem_busy),
        .fetch_ex   (fetch_ex),
        .mal_insn   (mal_insn),
        .badaddr    (badaddr)
    );

    // Register fields out to the execute stage
    assign fe_token      = fetch_ex.token;
    assign fe_pc         = fetch_ex.pc;
    assign fe_pc4        = fetch_ex.pc4;
    assign fe_instr      = fetch_ex.instr;
    assign fe_prediction = fetch_ex.prediction;

endmodule

// ==== sim/fetch_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// Property checker for the fetch subsystem
// Reset quiet bus, first fetch address, pc4, stall hold,
// flush on change of flow and misaligned fetch report
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_chk (
    input logic             CLK,
    input logic             nRST,
    input fetch_pkg::word_t imem_addr,
    input logic             imem_ren,
    input logic             ex_stall,
    input logic             ex_redirect,
    input fetch_pkg::word_t ex_brj_addr,
    input logic             priv_insert,
    input logic             fe_token,
    input fetch_pkg::word_t fe_pc,
    input fetch_pkg::word_t fe_pc4,
    input fetch_pkg::word_t fe_instr,
    input logic             fe_prediction,
    input logic             mal_insn,
    input fetch_pkg::word_t badaddr
);

    // Count of failed properties
    int err_count = 0;

    // No read and only bubbles while reset is held
    a_reset_quiet: assert property (@(posedge CLK) !nRST |-> !imem_ren && !fe_token)
        else begin
            $error("bus read or token seen during reset");
            err_count++;
        end

    // First read after reset goes to the reset vector
    a_first_fetch: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(imem_ren) |-> imem_addr == 32'h8000_0000)
        else begin
            $error("first fetch not at the reset vector");
            err_count++;
        end

    a_pc4: assert property (@(posedge CLK) disable iff (!nRST)
        fe_token |-> fe_pc4 == fe_pc + 32'd4)
        else begin
            $error("fe_pc4 differs from fe_pc plus 4");
            err_count++;
        end

    // Execute holding a live token keeps the whole register
    a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        fe_token && ex_stall && !ex_redirect && !priv_insert
        |=> $stable({fe_token, fe_pc, fe_pc4, fe_instr, fe_prediction}))
        else begin
            $error("register changed while execute stalled");
            err_count++;
        end

    // Redirect or trap leaves a bubble behind
    a_flow_flush: assert property (@(posedge CLK) disable iff (!nRST)
        ex_redirect || priv_insert |=> !fe_token)
        else begin
            $error("token survived a redirect or trap");
            err_count++;
        end

    // Fetch at a redirect target reports that address
    // Flag set only for nonzero low bits of the target
    a_misalign: assert property (@(posedge CLK) disable iff (!nRST)
        ex_redirect && !priv_insert
        |=> badaddr == $past(ex_brj_addr)
            && mal_insn == ($past(ex_brj_addr[1:0]) != 2'b00))
        else begin
            $error("misaligned fetch report wrong");
            err_count++;
        end

endmodule

bind fetch_top fetch_chk u_chk (
    .CLK           (CLK),
    .nRST          (nRST),
    .imem_addr     (imem_addr),
    .imem_ren      (imem_ren),
    .ex_stall      (ex_stall),
    .ex_redirect   (ex_redirect),
    .ex_brj_addr   (ex_brj_addr),
    .priv_insert   (priv_insert),
    .fe_token      (fe_token),
    .fe_pc         (fe_pc),
    .fe_pc4        (fe_pc4),
    .fe_instr      (fe_instr),
    .fe_prediction (fe_prediction),
    .mal_insn      (mal_insn),
    .badaddr       (badaddr)
);

// ==== sim/tb_fetch_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the fetch subsystem
// Clock, reset, hashed instruction memory, xorshift busy and stall,
// redirect, trap, BTB and misalignment sequences
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam word_t START_PC   = 32'h8000_0000;
    localparam int    WAIT_LIMIT = 50;

    logic  CLK;
    logic  nRST;
    word_t imem_addr;
    logic  imem_ren;
    word_t imem_rdata;
    logic  imem_busy;
    logic  ex_stall;
    logic  ex_redirect;
    word_t ex_brj_addr;
    logic  update_en;
    word_t update_pc;
    word_t update_target;
    logic  update_taken;
    logic  priv_insert;
    word_t priv_pc;
    logic  fe_token;
    word_t fe_pc;
    word_t fe_pc4;
    word_t fe_instr;
    logic  fe_prediction;
    logic  mal_insn;
    word_t badaddr;

    word_t rng_state;
    word_t exp_pc;
    logic  load_due;

    fetch_top UUT (
        .CLK (CLK), .nRST (nRST),
        .imem_addr (imem_addr), .imem_ren (imem_ren),
        .imem_rdata (imem_rdata), .imem_busy (imem_busy),
        .ex_stall (ex_stall), .ex_redirect (ex_redirect), .ex_brj_addr (ex_brj_addr),
        .update_en (update_en), .update_pc (update_pc),
        .update_target (update_target), .update_taken (update_taken),
        .priv_insert (priv_insert), .priv_pc (priv_pc),
        .fe_token (fe_token), .fe_pc (fe_pc), .fe_pc4 (fe_pc4),
        .fe_instr (fe_instr), .fe_prediction (fe_prediction),
        .mal_insn (mal_insn), .badaddr (badaddr)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory content, hash of the full address
    function automatic word_t mem_word(input word_t addr);
        return xorshift(addr ^ 32'h5bd1_e995);
    endfunction

    function automatic word_t byte_swap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Bus word for the current address, ready before the next edge
    always @(negedge CLK) begin
        imem_rdata <= mem_word(imem_addr);
    end

    // Bound checker failures end the run
    always @(negedge CLK) begin
        if (UUT.u_chk.err_count != 0) begin
            $display("a property of the bound checker failed");
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic drive_random();
        rng_state = xorshift(rng_state);
        // Roughly one cycle in four each
        imem_busy = (rng_state[1:0] == 2'b00);
        ex_stall  = (rng_state[4:3] == 2'b00);
    endtask

    // Bounded wait for a live token, random or quiet back-pressure
    task automatic wait_token(input string name, input logic random_on);
        int n;
        n = 0;
        while (!fe_token && n < WAIT_LIMIT) begin
            if (random_on) begin
                drive_random();
            end else begin
                imem_busy = 1'b0;
                ex_stall  = 1'b0;
            end
            @(negedge CLK);
            n++;
        end
        if (!fe_token) begin
            $display("no instruction reached execute in time during %s", name);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic redirect(input word_t addr);
        ex_redirect = 1'b1;
        ex_brj_addr = addr;
        @(negedge CLK);
        ex_redirect = 1'b0;
    endtask

    task automatic train(input word_t pc, input word_t target, input logic taken);
        update_en     = 1'b1;
        update_pc     = pc;
        update_target = target;
        update_taken  = taken;
        @(negedge CLK);
        update_en = 1'b0;
    endtask

    initial begin
        nRST = 1'b0;
        imem_rdata = '0;
        imem_busy = 1'b0;
        ex_stall = 1'b0;
        ex_redirect = 1'b0;
        ex_brj_addr = '0;
        update_en = 1'b0;
        update_pc = '0;
        update_target = '0;
        update_taken = 1'b0;
        priv_insert = 1'b0;
        priv_pc = '0;
        rng_state = 32'h702d;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        // Ready flag rises on this edge
        @(negedge CLK);
        check_value("reset_pc", START_PC, imem_addr);

        // Sequential fetch, a load is due after a cycle without busy or stall
        exp_pc = START_PC;
        load_due = 1'b0;
        repeat (200) begin
            if (load_due) begin
                check_value("seq_token", 32'd1, {31'd0, fe_token});
                check_value("seq_pc", exp_pc, fe_pc);
                check_value("seq_instr", byte_swap(mem_word(exp_pc)), fe_instr);
                exp_pc = exp_pc + 32'd4;
            end
            drive_random();
            load_due = !imem_busy && !ex_stall;
            @(negedge CLK);
        end

        // Redirect under busy and stall
        imem_busy = 1'b1;
        ex_stall  = 1'b1;
        redirect(32'h8000_1230);
        check_value("redirect_bubble", 32'd0, {31'd0, fe_token});
        wait_token("redirect", 1'b1);
        check_value("redirect_pc", 32'h8000_1230, fe_pc);

        // Trap beats a redirect in the same cycle
        priv_insert = 1'b1;
        priv_pc     = 32'h8000_0800;
        redirect(32'h8000_2000);
        priv_insert = 1'b0;
        check_value("trap_bubble", 32'd0, {31'd0, fe_token});
        wait_token("trap", 1'b1);
        check_value("trap_pc", 32'h8000_0800, fe_pc);

        // Taken branch learned by the BTB
        imem_busy = 1'b0;
        ex_stall  = 1'b0;
        train(32'h8000_0100, 32'h8000_0200, 1'b1);
        redirect(32'h8000_0100);
        wait_token("predict_taken", 1'b0);
        check_value("taken_pc", 32'h8000_0100, fe_pc);
        check_value("taken_pred", 32'd1, {31'd0, fe_prediction});
        @(negedge CLK);
        check_value("taken_target", 32'h8000_0200, fe_pc);

        // Two fall-throughs bring the counter below taken
        train(32'h8000_0100, 32'h8000_0200, 1'b0);
        train(32'h8000_0100, 32'h8000_0200, 1'b0);
        redirect(32'h8000_0100);
        wait_token("predict_not_taken", 1'b0);
        check_value("not_taken_pc", 32'h8000_0100, fe_pc);
        check_value("not_taken_pred", 32'd0, {31'd0, fe_prediction});
        @(negedge CLK);
        check_value("not_taken_next", 32'h8000_0104, fe_pc);

        // Halfword aligned target
        redirect(32'h8000_0402);
        check_value("mal_insn", 32'd1, {31'd0, mal_insn});
        check_value("badaddr", 32'h8000_0402, badaddr);
        repeat (2) @(negedge CLK);

        if (UUT.u_chk.err_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== build.f ====
hdl/fetch_pkg.sv
hdl/fetch_hazard_if.sv
hdl/predictor_if.sv
hdl/branch_target_buffer.sv
hdl/fetch_hazard_unit.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
sim/fetch_chk.sv
sim/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_hazard_if.sv
      - hdl/predictor_if.sv
      - hdl/branch_target_buffer.sv
      - hdl/fetch_hazard_unit.sv
      - hdl/fetch_stage.sv
      - hdl/fetch_top.sv
  - target: simulation
    files:
      - sim/fetch_chk.sv
      - sim/tb_fetch_top.sv
